// File: filelist.f
src/dcache_pkg.sv
src/line_store.sv
src/port_lookup.sv
src/update_ctrl.sv
src/backing_mem.sv
src/dcache_top.sv
tests/tb_dcache.sv

// File: Makefile
TOP = tb_dcache

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir

// File: tests/tb_dcache.sv
// ----------------------------------------------------------------------
// data cache testbench
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;

    localparam int    NUM_RD   = 3;
    localparam int    MAX_WAIT = 20;
    localparam word_t INIT_XOR = 32'h5a5a0000;

    logic    clk;
    logic    rst;
    rd_req_t rd_req [NUM_RD];
    rd_rsp_t rd_rsp [NUM_RD];
    wr_req_t wr_req;
    logic    wr_hit;
    logic    wr_hit_valid;

    // inputs for the next rising edge
    rd_req_t nxt_rd [NUM_RD];
    wr_req_t nxt_wr;

    // flat memory image and shadow tags
    word_t            ref_mem   [1 << ADDR_W];
    logic             ref_valid [NUM_LINES];
    logic [TAG_W-1:0] ref_tag   [NUM_LINES];
    rd_rsp_t          exp_rd    [NUM_RD];
    logic             exp_wr_valid;
    logic             exp_wr_hit;
    bit               started;

    int rd_errors;
    int wr_errors;
    int wait_errors;
    int seed;

    dcache_top #(.NUM_RD(NUM_RD)) dut_i (
        .clk          (clk),
        .rst          (rst),
        .rd_req       (rd_req),
        .rd_rsp       (rd_rsp),
        .wr_req       (wr_req),
        .wr_hit       (wr_hit),
        .wr_hit_valid (wr_hit_valid)
    );

    always #10 clk = ~clk;

    function automatic word_t init_word(input logic [ADDR_W-1:0] a);
        return word_t'(a) ^ INIT_XOR;
    endfunction

    // expected response from the state before the coming edge
    function automatic rd_rsp_t expect_read(input rd_req_t req, input logic in_rst);
        rd_rsp_t            r;
        logic [INDEX_W-1:0] idx;
        logic [ADDR_W-1:0]  a;
        idx     = req.addr.cache.index;
        a       = req.addr;
        r.valid = req.en && !in_rst;
        r.hit   = r.valid && ref_valid[idx] && (ref_tag[idx] == req.addr.cache.tag);
        r.data  = ref_mem[a];
        return r;
    endfunction

    // lowest missing port fills unless a write comes first
    function automatic void update_model();
        logic              filled;
        logic [ADDR_W-1:0] a;
        filled = 1'b0;
        a      = wr_req.addr;
        if (rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                ref_valid[i] = 1'b0;
            end
        end else if (wr_req.en) begin
            ref_mem[a] = wr_req.data;
            ref_valid[wr_req.addr.cache.index] = 1'b1;
            ref_tag[wr_req.addr.cache.index]   = wr_req.addr.cache.tag;
        end else begin
            for (int p = 0; p < NUM_RD; p++) begin
                if (!filled && exp_rd[p].valid && !exp_rd[p].hit) begin
                    ref_valid[rd_req[p].addr.cache.index] = 1'b1;
                    ref_tag[rd_req[p].addr.cache.index]   = rd_req[p].addr.cache.tag;
                    filled = 1'b1;
                end
            end
        end
    endfunction

    function automatic addr_u rand_addr();
        logic [31:0] r;
        addr_u       a;
        r = $random(seed);
        a = '0;
        // 64 words over 4 tags and 4 lines
        a.cache.tag    = {2'b00, r[1:0]};
        a.cache.index  = {2'b00, r[3:2]};
        a.cache.offset = r[5:4];
        return a;
    endfunction

    task automatic check_rd_rsp(input int port, input rd_rsp_t got, input rd_rsp_t want);
        if (got.valid !== want.valid) begin
            $display("ERR rd_rsp[%0d].valid got %h exp %h", port, got.valid, want.valid);
            rd_errors++;
        end else if (got.hit !== want.hit) begin
            $display("ERR rd_rsp[%0d].hit got %h exp %h", port, got.hit, want.hit);
            rd_errors++;
        end else if (want.valid && got.data !== want.data) begin
            $display("ERR rd_rsp[%0d].data got %h exp %h", port, got.data, want.data);
            rd_errors++;
        end
    endtask

    task automatic check_wr_hit(input string name, input logic got, input logic want);
        if (got !== want) begin
            $display("ERR %s got %h exp %h", name, got, want);
            wr_errors++;
        end
    endtask

    always @(negedge clk) begin
        if (started) begin
            for (int p = 0; p < NUM_RD; p++) begin
                check_rd_rsp(p, rd_rsp[p], exp_rd[p]);
            end
            check_wr_hit("wr_hit_valid", wr_hit_valid, exp_wr_valid);
            check_wr_hit("wr_hit", wr_hit, exp_wr_hit);
        end
        for (int p = 0; p < NUM_RD; p++) begin
            exp_rd[p] = expect_read(rd_req[p], rst);
        end
        exp_wr_valid = wr_req.en && !rst;
        exp_wr_hit   = exp_wr_valid && ref_valid[wr_req.addr.cache.index] &&
                       (ref_tag[wr_req.addr.cache.index] == wr_req.addr.cache.tag);
        update_model();
        if (rst) begin
            started = 1'b1;
        end
    end

    task automatic stage_idle();
        for (int p = 0; p < NUM_RD; p++) begin
            nxt_rd[p] = '0;
        end
        nxt_wr = '0;
    endtask

    task automatic apply_stage();
        @(posedge clk);
        for (int p = 0; p < NUM_RD; p++) begin
            rd_req[p] <= nxt_rd[p];
        end
        wr_req <= nxt_wr;
    endtask

    task automatic wait_rd_valid(input int port);
        int n;
        n = 0;
        @(negedge clk);
        while (!rd_rsp[port].valid && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!rd_rsp[port].valid) begin
            $display("timeout while waiting for a read response on port %0d", port);
            wait_errors++;
        end
    endtask

    task automatic wait_wr_valid();
        int n;
        n = 0;
        @(negedge clk);
        while (!wr_hit_valid && n < MAX_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!wr_hit_valid) begin
            $display("timeout while waiting for the write result");
            wait_errors++;
        end
    endtask

    task automatic read_check(input int port, input logic [ADDR_W-1:0] a,
                              input logic hit, input word_t data);
        rd_rsp_t want;
        want = '{valid: 1'b1, hit: hit, data: data};
        stage_idle();
        nxt_rd[port].en   = 1'b1;
        nxt_rd[port].addr = a;
        apply_stage();
        stage_idle();
        apply_stage();
        wait_rd_valid(port);
        check_rd_rsp(port, rd_rsp[port], want);
    endtask

    task automatic write_check(input logic [ADDR_W-1:0] a, input word_t data, input logic hit);
        stage_idle();
        nxt_wr = '{en: 1'b1, addr: a, data: data};
        apply_stage();
        stage_idle();
        apply_stage();
        wait_wr_valid();
        check_wr_hit("wr_hit", wr_hit, hit);
    endtask

    initial begin
        rd_rsp_t     want;
        logic [31:0] r;
        seed = 32'hf02a;
        clk  = 1'b0;
        rst  = 1'b1;
        stage_idle();
        for (int p = 0; p < NUM_RD; p++) begin
            rd_req[p] = '0;
        end
        wr_req = '0;
        for (int a = 0; a < (1 << ADDR_W); a++) begin
            ref_mem[a] = init_word(ADDR_W'(a));
        end
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // idle cycles before a cold miss
        repeat (4) apply_stage();
        read_check(0, 10'h013, 1'b0, init_word(10'h013));

        // back-to-back reads of one address
        stage_idle();
        nxt_rd[0] = '{en: 1'b1, addr: 10'h020};
        apply_stage();
        apply_stage();
        wait_rd_valid(0);
        want = '{valid: 1'b1, hit: 1'b0, data: init_word(10'h020)};
        check_rd_rsp(0, rd_rsp[0], want);
        stage_idle();
        apply_stage();
        @(negedge clk);
        want.hit = 1'b1;
        check_rd_rsp(0, rd_rsp[0], want);

        // only port 0 fills among three misses
        nxt_rd[0] = '{en: 1'b1, addr: 10'h104};
        nxt_rd[1] = '{en: 1'b1, addr: 10'h108};
        nxt_rd[2] = '{en: 1'b1, addr: 10'h10c};
        apply_stage();
        read_check(0, 10'h104, 1'b1, init_word(10'h104));
        read_check(1, 10'h108, 1'b0, init_word(10'h108));
        read_check(2, 10'h10c, 1'b0, init_word(10'h10c));

        // write then read plus a read in the write's own cycle
        write_check(10'h030, 32'hcafe0001, 1'b0);
        read_check(1, 10'h030, 1'b1, 32'hcafe0001);
        stage_idle();
        nxt_wr    = '{en: 1'b1, addr: 10'h031, data: 32'hcafe0002};
        nxt_rd[0] = '{en: 1'b1, addr: 10'h031};
        apply_stage();
        stage_idle();
        apply_stage();
        wait_rd_valid(0);
        want = '{valid: 1'b1, hit: 1'b1, data: init_word(10'h031)};
        check_rd_rsp(0, rd_rsp[0], want);
        check_wr_hit("wr_hit", wr_hit, 1'b1);
        read_check(0, 10'h031, 1'b1, 32'hcafe0002);

        // dirty eviction and write-back
        write_check(10'h044, 32'hbeef0044, 1'b0);
        write_check(10'h084, 32'hbeef0084, 1'b0);
        read_check(2, 10'h044, 1'b0, 32'hbeef0044);

        // random traffic on every port
        repeat (2000) begin
            for (int p = 0; p < NUM_RD; p++) begin
                nxt_rd[p].en   = 1'b1;
                nxt_rd[p].addr = rand_addr();
            end
            r = $random(seed);
            nxt_wr.en   = r[0];
            nxt_wr.addr = rand_addr();
            nxt_wr.data = $random(seed);
            apply_stage();
        end
        stage_idle();
        repeat (2) apply_stage();
        @(negedge clk);

        $display("errors: rd_rsp %0d, wr_hit %0d, timeouts %0d",
                 rd_errors, wr_errors, wait_errors);
        if (rd_errors + wr_errors + wait_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src/dcache_top.sv
// ----------------------------------------------------------------------
// write-back data cache top
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int NUM_RD = 3
) (
    input  logic                clk,
    input  logic                rst,
    input  dcache_pkg::rd_req_t rd_req [NUM_RD],
    output dcache_pkg::rd_rsp_t rd_rsp [NUM_RD],
    input  dcache_pkg::wr_req_t wr_req,
    output logic                wr_hit,
    output logic                wr_hit_valid
);
    import dcache_pkg::*;

    logic [INDEX_W-1:0] rd_index     [NUM_RD];
    line_t              rd_line      [NUM_RD];
    fill_req_t          fill         [NUM_RD];
    logic [BLOCK_W-1:0] mem_rd_block [NUM_RD+1];
    block_t             mem_rd_data  [NUM_RD+1];
    line_t              wr_line;

    logic               upd_en;
    logic [INDEX_W-1:0] upd_index;
    line_t              upd_line;
    logic               mem_we;
    logic [BLOCK_W-1:0] mem_wblock;
    block_t             mem_wdata;

    for (genvar g = 0; g < NUM_RD; g++) begin : g_port
        assign rd_index[g]     = rd_req[g].addr.cache.index;
        assign mem_rd_block[g] = rd_req[g].addr.mem.block;

        port_lookup u_lookup (
            .clk       (clk),
            .rst       (rst),
            .req       (rd_req[g]),
            .line      (rd_line[g]),
            .mem_block (mem_rd_data[g]),
            .rsp       (rd_rsp[g]),
            .fill      (fill[g])
        );
    end

    assign mem_rd_block[NUM_RD] = wr_req.addr.mem.block;

    // write-side view follows the chosen update, so fills see their victim too
    line_store #(.NUM_RD(NUM_RD)) u_lines (
        .clk       (clk),
        .rst       (rst),
        .rd_index  (rd_index),
        .wr_index  (upd_index),
        .rd_line   (rd_line),
        .wr_line   (wr_line),
        .upd_en    (upd_en),
        .upd_index (upd_index),
        .upd_line  (upd_line)
    );

    update_ctrl #(.NUM_RD(NUM_RD)) u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .wr_req       (wr_req),
        .wr_line      (wr_line),
        .wr_mem_block (mem_rd_data[NUM_RD]),
        .fill         (fill),
        .rd_index     (rd_index),
        .upd_en       (upd_en),
        .upd_index    (upd_index),
        .upd_line     (upd_line),
        .mem_we       (mem_we),
        .mem_wblock   (mem_wblock),
        .mem_wdata    (mem_wdata),
        .wr_hit       (wr_hit),
        .wr_hit_valid (wr_hit_valid)
    );

    backing_mem #(.NUM_RD(NUM_RD)) u_mem (
        .clk      (clk),
        .rd_block (mem_rd_block),
        .rd_data  (mem_rd_data),
        .we       (mem_we),
        .wblock   (mem_wblock),
        .wdata    (mem_wdata)
    );

endmodule

`default_nettype wire

// File: src/backing_mem.sv
// ----------------------------------------------------------------------
// backing memory model
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module backing_mem #(
    parameter int NUM_RD = 3
) (
    input  logic                           clk,
    input  logic [dcache_pkg::BLOCK_W-1:0] rd_block [NUM_RD+1],
    output dcache_pkg::block_t             rd_data [NUM_RD+1],
    input  logic                           we,
    input  logic [dcache_pkg::BLOCK_W-1:0] wblock,
    input  dcache_pkg::block_t             wdata
);
    import dcache_pkg::*;

    block_t mem [NUM_BLOCKS];

    // start pattern is word address xor constant
    initial begin
        for (int b = 0; b < NUM_BLOCKS; b++) begin
            for (int w = 0; w < WORDS_PER_BLOCK; w++) begin
                mem[b][w] = word_t'(ADDR_W'(b * WORDS_PER_BLOCK + w)) ^ 32'h5a5a0000;
            end
        end
    end

    // last read port belongs to the write side
    always_comb begin
        for (int p = 0; p <= NUM_RD; p++) begin
            rd_data[p] = mem[rd_block[p]];
        end
    end

    always @(posedge clk) begin
        if (we) begin
            mem[wblock] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: src/update_ctrl.sv
// ----------------------------------------------------------------------
// line update and write-back control
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module update_ctrl #(
    parameter int NUM_RD = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  dcache_pkg::wr_req_t            wr_req,
    input  dcache_pkg::line_t              wr_line,
    input  dcache_pkg::block_t             wr_mem_block,
    input  dcache_pkg::fill_req_t          fill [NUM_RD],
    input  logic [dcache_pkg::INDEX_W-1:0] rd_index [NUM_RD],
    output logic                           upd_en,
    output logic [dcache_pkg::INDEX_W-1:0] upd_index,
    output dcache_pkg::line_t              upd_line,
    output logic                           mem_we,
    output logic [dcache_pkg::BLOCK_W-1:0] mem_wblock,
    output dcache_pkg::block_t             mem_wdata,
    output logic                           wr_hit,
    output logic                           wr_hit_valid
);
    import dcache_pkg::*;

    localparam int SEL_W = (NUM_RD > 1) ? $clog2(NUM_RD) : 1;

    logic             fill_any;
    logic [SEL_W-1:0] fill_sel;
    logic             wr_hit_now;
    block_t           wr_block;

    // lowest-numbered requesting port wins
    always_comb begin
        fill_any = 1'b0;
        fill_sel = '0;
        for (int i = NUM_RD - 1; i >= 0; i--) begin
            if (fill[i].req) begin
                fill_any = 1'b1;
                fill_sel = SEL_W'(i);
            end
        end
    end

    // write takes priority over any fill
    assign upd_en    = wr_req.en || fill_any;
    assign upd_index = wr_req.en ? wr_req.addr.cache.index : rd_index[fill_sel];

    // wr_line shows the line at upd_index
    assign wr_hit_now = wr_line.valid && (wr_line.tag == wr_req.addr.cache.tag);

    // merge the write word into cached or fetched block
    always_comb begin
        wr_block = wr_hit_now ? wr_line.data : wr_mem_block;
        wr_block[wr_req.addr.cache.offset] = wr_req.data;
    end

    always_comb begin
        if (wr_req.en) begin
            upd_line = '{
                valid: 1'b1,
                dirty: 1'b1,
                tag:   wr_req.addr.cache.tag,
                data:  wr_block
            };
        end else begin
            upd_line = '{
                valid: 1'b1,
                dirty: 1'b0,
                tag:   fill[fill_sel].tag,
                data:  fill[fill_sel].block
            };
        end
    end

    // evict a dirty line of another tag
    assign mem_we     = upd_en && wr_line.valid && wr_line.dirty &&
                        (wr_line.tag != upd_line.tag);
    assign mem_wblock = {wr_line.tag, upd_index};
    assign mem_wdata  = wr_line.data;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_hit       <= 1'b0;
            wr_hit_valid <= 1'b0;
        end else begin
            wr_hit       <= wr_req.en && wr_hit_now;
            wr_hit_valid <= wr_req.en;
        end
    end

    // write-back only goes with the winner's own line
    a_wb_with_update: assert property (
        @(posedge clk) disable iff (rst)
        mem_we |-> wr_req.en ||
                   (fill[fill_sel].req && (fill[fill_sel].index == upd_index))
    ) else $error("write-back without its line update");

endmodule

`default_nettype wire

// File: src/port_lookup.sv
// ----------------------------------------------------------------------
// read port lookup
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module port_lookup (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::rd_req_t   req,
    input  dcache_pkg::line_t     line,
    input  dcache_pkg::block_t    mem_block,
    output dcache_pkg::rd_rsp_t   rsp,
    output dcache_pkg::fill_req_t fill
);
    import dcache_pkg::*;

    logic  hit;
    word_t word;
    logic  rsp_valid;
    logic  rsp_hit;
    word_t rsp_data;

    assign hit = line.valid && (line.tag == req.addr.cache.tag);

    // miss data comes straight from the memory block
    assign word = hit ? line.data[req.addr.cache.offset]
                      : mem_block[req.addr.cache.offset];

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp_hit   <= 1'b0;
        end else begin
            rsp_valid <= req.en;
            rsp_hit   <= req.en && hit;
        end
    end

    always_ff @(posedge clk) begin
        if (req.en) begin
            rsp_data <= word;
        end
    end

    assign rsp = '{valid: rsp_valid, hit: rsp_hit, data: rsp_data};

    // ask for the line on an enabled miss
    assign fill = '{
        req:   req.en && !hit,
        index: req.addr.cache.index,
        tag:   req.addr.cache.tag,
        block: mem_block
    };

    // a valid line must hold known data
    a_hit_on_valid: assert property (
        @(posedge clk) disable iff (rst)
        rsp.hit |-> rsp.valid && !$isunknown(rsp.data)
    ) else $error("hit returned unknown data");

endmodule

`default_nettype wire

// File: src/line_store.sv
// ----------------------------------------------------------------------
// cache line arrays
// ----------------------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module line_store #(
    parameter int NUM_RD = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [dcache_pkg::INDEX_W-1:0] rd_index [NUM_RD],
    input  logic [dcache_pkg::INDEX_W-1:0] wr_index,
    output dcache_pkg::line_t              rd_line [NUM_RD],
    output dcache_pkg::line_t              wr_line,
    input  logic                           upd_en,
    input  logic [dcache_pkg::INDEX_W-1:0] upd_index,
    input  dcache_pkg::line_t              upd_line
);
    import dcache_pkg::*;

    logic             line_valid [NUM_LINES];
    logic             line_dirty [NUM_LINES];
    logic [TAG_W-1:0] line_tag   [NUM_LINES];
    block_t           line_data  [NUM_LINES];

    // status bits
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_LINES; i++) begin
                line_valid[i] <= 1'b0;
                line_dirty[i] <= 1'b0;
            end
        end else if (upd_en) begin
            line_valid[upd_index] <= upd_line.valid;
            line_dirty[upd_index] <= upd_line.dirty;
        end
    end

    // tag and data
    always_ff @(posedge clk) begin
        if (upd_en) begin
            line_tag[upd_index]  <= upd_line.tag;
            line_data[upd_index] <= upd_line.data;
        end
    end

    // one combinational view per read port
    always_comb begin
        for (int p = 0; p < NUM_RD; p++) begin
            rd_line[p] = '{
                valid: line_valid[rd_index[p]],
                dirty: line_dirty[rd_index[p]],
                tag:   line_tag[rd_index[p]],
                data:  line_data[rd_index[p]]
            };
        end
    end

    assign wr_line = '{
        valid: line_valid[wr_index],
        dirty: line_dirty[wr_index],
        tag:   line_tag[wr_index],
        data:  line_data[wr_index]
    };

    // an updated line is valid from the next cycle on
    a_upd_valid: assert property (
        @(posedge clk) disable iff (rst)
        upd_en |=> line_valid[$past(upd_index)]
    ) else $error("line update left index %0h invalid", $past(upd_index));

endmodule

`default_nettype wire

// File: src/dcache_pkg.sv
// ----------------------------------------------------------------------
// data cache shared types
// ----------------------------------------------------------------------
`default_nettype none

package dcache_pkg;

    // word-addressed geometry
    localparam int OFFSET_W = 2;
    localparam int INDEX_W  = 4;
    localparam int TAG_W    = 4;
    localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;
    localparam int BLOCK_W  = TAG_W + INDEX_W;

    localparam int WORDS_PER_BLOCK = 1 << OFFSET_W;
    localparam int NUM_LINES       = 1 << INDEX_W;
    localparam int NUM_BLOCKS      = 1 << BLOCK_W;

    typedef logic [31:0] word_t;

    // word 0 sits at offset 0
    typedef word_t [WORDS_PER_BLOCK-1:0] block_t;

    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } cache_addr_t;

    typedef struct packed {
        logic [BLOCK_W-1:0]  block;
        logic [OFFSET_W-1:0] offset;
    } mem_addr_t;

    // same address bits seen by the cache and by the memory
    typedef union packed {
        cache_addr_t cache;
        mem_addr_t   mem;
    } addr_u;

    typedef struct packed {
        logic  en;
        addr_u addr;
    } rd_req_t;

    typedef struct packed {
        logic  valid;
        logic  hit;
        word_t data;
    } rd_rsp_t;

    typedef struct packed {
        logic  en;
        addr_u addr;
        word_t data;
    } wr_req_t;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
        block_t           data;
    } line_t;

    // read miss with its block already fetched from memory
    typedef struct packed {
        logic               req;
        logic [INDEX_W-1:0] index;
        logic [TAG_W-1:0]   tag;
        block_t             block;
    } fill_req_t;

endpackage

`default_nettype wire
